// File: flist.f
+incdir+verification
source/jtag_pkg.sv
source/dial_pkg.sv
source/tap_decoder.sv
source/ascii_decoder.sv
source/dial_counter.sv
source/tap_encoder.sv
source/user_logic.sv
verification/tb_user_logic.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_user_logic -f flist.f -o sim_tb_user_logic
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_user_logic > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0

// File: source/ascii_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ascii_decoder
    import jtag_pkg::*, dial_pkg::*;
(
    input wire tck,
    input wire test_logic_reset,
    input wire byte_t byte_data,
    input wire byte_valid,
    output step_t right_steps,
    output logic right_steps_valid,
    output logic end_of_file
);

    parse_state_t state;
    logic turn_left;                                       // Direction of the current line.
    step_t count;                                          // Decimal count so far, mod 100.

    logic is_digit;
    logic is_direction;
    logic is_newline;
    logic is_eot;
    step_t folded_count;
    step_t line_steps;

    // Only the last two decimal digits survive a mod 100 fold.
    function automatic step_t fold_digit(input step_t value, input byte_t ascii);
        step_t ones;
        step_t digit;
        ones = value % step_t'(DECIMAL_BASE);
        digit = step_t'(ascii - ASCII_ZERO);
        return step_t'(ones * step_t'(DECIMAL_BASE)) + digit;
    endfunction

    // **************************************************
    // Byte classification
    // **************************************************
    always_comb begin
        is_digit = (byte_data >= ASCII_ZERO) && (byte_data <= ASCII_NINE);
        is_direction = (byte_data == ASCII_R) || (byte_data == ASCII_L);
        is_newline = (byte_data == ASCII_NEWLINE);
        is_eot = (byte_data == ASCII_EOT);
        folded_count = fold_digit(count, byte_data);
        if (turn_left && (count != '0)) begin
            line_steps = step_t'(DIAL_SIZE) - count;       // Left turn as a right turn.
        end else begin
            line_steps = count;
        end
    end

    // **************************************************
    // Line parser
    // **************************************************
    always_ff @(posedge tck) begin : parse
        right_steps_valid <= 1'b0;
        end_of_file <= 1'b0;
        if (test_logic_reset) begin
            state <= IDLE;
            turn_left <= 1'b0;
            count <= '0;
            right_steps <= '0;
        end else if (byte_valid) begin
            unique case (state)
                IDLE: begin
                    if (is_direction) begin
                        turn_left <= (byte_data == ASCII_L);
                        count <= '0;
                        state <= DIGITS;
                    end else if (is_eot) begin
                        end_of_file <= 1'b1;
                        state <= DONE;
                    end
                end
                DIGITS: begin
                    if (is_direction) begin
                        turn_left <= (byte_data == ASCII_L);   // Restarts the line.
                        count <= '0;
                    end else if (is_digit) begin
                        count <= folded_count;
                    end else if (is_newline) begin
                        right_steps <= line_steps;
                        right_steps_valid <= 1'b1;
                        state <= IDLE;
                    end else if (is_eot) begin
                        right_steps <= line_steps;             // Last line without newline.
                        right_steps_valid <= 1'b1;
                        end_of_file <= 1'b1;
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= DONE;                         // Held until reset.
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/dial_counter.sv
`timescale 1ns/1ps
`default_nettype none

module dial_counter
    import jtag_pkg::*, dial_pkg::*;
(
    input wire tck,
    input wire test_logic_reset,
    input wire step_t right_steps,
    input wire right_steps_valid,
    input wire end_of_file,
    output result_t zero_count,
    output logic count_valid
);

    position_t position;
    position_t next_position;
    dial_sum_t sum;
    logic step_taken;                                      // Position was updated last cycle.
    logic end_of_file_d1;

    // **************************************************
    // Stage 1, modulo 100 addition
    // **************************************************
    always_comb begin
        sum = dial_sum_t'(position) + dial_sum_t'(right_steps);
        if (sum >= dial_sum_t'(DIAL_SIZE)) begin
            next_position = position_t'(sum - dial_sum_t'(DIAL_SIZE));
        end else begin
            next_position = position_t'(sum);
        end
    end

    always_ff @(posedge tck) begin : turn_dial
        if (test_logic_reset) begin
            position <= DIAL_START;
            step_taken <= 1'b0;
        end else begin
            step_taken <= right_steps_valid;
            if (right_steps_valid) begin
                position <= next_position;
            end
        end
    end

    // **************************************************
    // Stage 2, zero landings and end of file
    // **************************************************
    always_ff @(posedge tck) begin : count_zeroes
        if (test_logic_reset) begin
            zero_count <= '0;
            end_of_file_d1 <= 1'b0;
            count_valid <= 1'b0;
        end else begin
            end_of_file_d1 <= end_of_file;
            count_valid <= end_of_file_d1;                 // Lines up with the last increment.
            if (step_taken && (position == '0)) begin
                zero_count <= zero_count + 1'b1;           // Wraps above 65535.
            end
        end
    end

endmodule

`default_nettype wire

// File: source/dial_pkg.sv
`default_nettype none

package dial_pkg;

    // **************************************************
    // Dial geometry
    // **************************************************
    localparam int DIAL_BITS = 7;
    localparam int DIAL_SIZE = 100;                        // Positions 0 to 99.
    localparam int DECIMAL_BASE = 10;

    typedef logic [DIAL_BITS-1:0] step_t;                  // Clockwise step, already mod 100.
    typedef logic [DIAL_BITS-1:0] position_t;              // Dial position, 0 to 99.
    typedef logic [DIAL_BITS:0] dial_sum_t;                // Position plus step, up to 198.

    localparam position_t DIAL_START = 7'd50;

    // **************************************************
    // Line parser states
    // **************************************************
    typedef enum logic [1:0] {
        IDLE,                                              // Between lines.
        DIGITS,                                            // Direction seen, reading count.
        DONE                                               // EOT seen, input ignored.
    } parse_state_t;

endpackage

`default_nettype wire

// File: source/jtag_pkg.sv
`default_nettype none

package jtag_pkg;

    // **************************************************
    // Byte framing on the user data register
    // **************************************************
    localparam int BYTE_BITS = 8;
    localparam int RESULT_BITS = 16;

    typedef logic [BYTE_BITS-1:0] byte_t;                  // One ASCII character.
    typedef logic [$clog2(BYTE_BITS)-1:0] bit_count_t;     // Bit index inside a byte.
    typedef logic [RESULT_BITS-1:0] result_t;              // Zero-landing count.

    localparam bit_count_t LAST_BIT = bit_count_t'(BYTE_BITS - 1);

    // **************************************************
    // ASCII codes seen in the input file
    // **************************************************
    localparam byte_t ASCII_EOT = 8'h04;                   // Ends the transfer.
    localparam byte_t ASCII_NEWLINE = 8'h0a;
    localparam byte_t ASCII_ZERO = 8'h30;
    localparam byte_t ASCII_NINE = 8'h39;
    localparam byte_t ASCII_L = 8'h4c;                     // Counter-clockwise turn.
    localparam byte_t ASCII_R = 8'h52;                     // Clockwise turn.

endpackage

`default_nettype wire

// File: source/tap_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tap_decoder
    import jtag_pkg::*;
(
    input wire tck,
    input wire tdi,
    input wire test_logic_reset,
    input wire ir_is_user,
    input wire shift_dr,
    input wire update_dr,
    output byte_t byte_data,
    output logic byte_valid
);

    byte_t shift_q;
    byte_t shift_next;
    bit_count_t bit_count;

    // TDI enters at the top so the first bit ends up as the LSB.
    always_comb begin
        shift_next = {tdi, shift_q[BYTE_BITS-1:1]};
    end

    always_ff @(posedge tck) begin : deserialize
        byte_valid <= 1'b0;
        if (test_logic_reset) begin
            shift_q <= '0;
            bit_count <= '0;
            byte_data <= '0;
        end else if (update_dr) begin
            bit_count <= '0;                               // Drops a partial byte.
        end else if (ir_is_user && shift_dr) begin
            shift_q <= shift_next;
            bit_count <= bit_count + 1'b1;                 // Wraps after the eighth bit.
            if (bit_count == LAST_BIT) begin
                byte_data <= shift_next;
                byte_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/tap_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tap_encoder
    import jtag_pkg::*;
(
    input wire tck,
    input wire test_logic_reset,
    input wire ir_is_user,
    input wire capture_dr,
    input wire shift_dr,
    input wire result_t zero_count,
    input wire count_valid,
    output logic tdo
);

    result_t result_q;                                     // Last complete count.
    result_t shift_q;

    // **************************************************
    // Result holding register
    // **************************************************
    always_ff @(posedge tck) begin : hold_result
        if (test_logic_reset) begin
            result_q <= '0;
        end else if (count_valid) begin
            result_q <= zero_count;
        end
    end

    // **************************************************
    // Capture and shift out, LSB first
    // **************************************************
    always_ff @(posedge tck) begin : shift_out
        if (test_logic_reset) begin
            shift_q <= '0;
        end else if (ir_is_user && capture_dr) begin
            shift_q <= result_q;
        end else if (ir_is_user && shift_dr) begin
            shift_q <= {1'b0, shift_q[RESULT_BITS-1:1]};
        end
    end

    // The LSB flop is the TDO register.
    assign tdo = shift_q[0];

endmodule

`default_nettype wire

// File: source/user_logic.sv
`timescale 1ns/1ps
`default_nettype none

module user_logic
    import jtag_pkg::*, dial_pkg::*;
(
    input wire tck,
    input wire tdi,
    output logic tdo,
    input wire test_logic_reset,
    input wire run_test_idle,                              // Not needed by this register.
    input wire ir_is_user,
    input wire capture_dr,
    input wire shift_dr,
    input wire update_dr
);

    byte_t byte_data;
    logic byte_valid;
    step_t right_steps;
    logic right_steps_valid;
    logic end_of_file;
    result_t zero_count;
    logic count_valid;

    // **************************************************
    // Inbound path, TDI to dial steps
    // **************************************************
    tap_decoder tap_decoder_i (
        .tck(tck),
        .tdi(tdi),
        .test_logic_reset(test_logic_reset),
        .ir_is_user(ir_is_user),
        .shift_dr(shift_dr),
        .update_dr(update_dr),
        .byte_data(byte_data),
        .byte_valid(byte_valid)
    );

    ascii_decoder ascii_decoder_i (
        .tck(tck),
        .test_logic_reset(test_logic_reset),
        .byte_data(byte_data),
        .byte_valid(byte_valid),
        .right_steps(right_steps),
        .right_steps_valid(right_steps_valid),
        .end_of_file(end_of_file)
    );

    // **************************************************
    // Dial arithmetic and readback
    // **************************************************
    dial_counter dial_counter_i (
        .tck(tck),
        .test_logic_reset(test_logic_reset),
        .right_steps(right_steps),
        .right_steps_valid(right_steps_valid),
        .end_of_file(end_of_file),
        .zero_count(zero_count),
        .count_valid(count_valid)
    );

    tap_encoder tap_encoder_i (
        .tck(tck),
        .test_logic_reset(test_logic_reset),
        .ir_is_user(ir_is_user),
        .capture_dr(capture_dr),
        .shift_dr(shift_dr),
        .zero_count(zero_count),
        .count_valid(count_valid),
        .tdo(tdo)
    );

endmodule

`default_nettype wire

// File: verification/tb_jtag_tasks.svh
`ifndef TB_JTAG_TASKS_SVH
`define TB_JTAG_TASKS_SVH

// Inputs change 2 ns after the rising edge.
task automatic next_cycle();
    @(posedge tck);
    #(DRIVE_DELAY);
endtask

task automatic apply_reset();
    test_logic_reset = 1'b1;
    repeat (RESET_CYCLES) next_cycle();
    test_logic_reset = 1'b0;
endtask

task automatic shift_bits(input byte_t value, input int count);
    for (int i = 0; i < count; i++) begin
        ir_is_user = 1'b1;
        shift_dr = 1'b1;
        tdi = value[i];                                    // LSB first.
        next_cycle();
    end
    shift_dr = 1'b0;
    tdi = 1'b0;
endtask

task automatic pulse_update();
    update_dr = 1'b1;
    next_cycle();
    update_dr = 1'b0;
endtask

task automatic add_text(input string text);
    for (int i = 0; i < text.len(); i++) begin
        file_q.push_back(byte_t'(text[i]));
    end
endtask

task automatic send_file();
    foreach (file_q[i]) begin
        shift_bits(file_q[i], BYTE_BITS);
    end
    pulse_update();
    repeat (SETTLE_CYCLES) next_cycle();
endtask

// Capture, then 16 shifts with TDI low so the parser sees only NUL bytes.
task automatic read_result(output result_t value);
    ir_is_user = 1'b1;
    capture_dr = 1'b1;
    next_cycle();
    capture_dr = 1'b0;
    captured = 1'b1;
    shift_dr = 1'b1;
    tdi = 1'b0;
    for (int i = 0; i < RESULT_BITS; i++) begin
        value[i] = tdo;
        next_cycle();
    end
    shift_dr = 1'b0;
    pulse_update();
endtask

task automatic check_result(input string name, input result_t expected);
    result_t actual;
    read_result(actual);
    check_name = name;
    expected_value = expected;
    read_value = actual;
    check_read = 1'b1;
    next_cycle();
    check_read = 1'b0;
    read_count++;
endtask

task automatic run_file(input string name, input string text);
    apply_reset();
    file_q.delete();
    add_text(text);
    file_q.push_back(ASCII_EOT);
    send_file();
    check_result(name, model_count());
endtask

`endif

// File: verification/tb_user_logic.sv
`timescale 1ns/1ps
`default_nettype none

module tb_user_logic
    import jtag_pkg::*, dial_pkg::*;
;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 16;
    localparam int SETTLE_CYCLES = 11;                     // EOT to readable result.
    localparam int RANDOM_LINES = 40;
    localparam int SEED = 32'hdf39;
    localparam int FILE_BYTE_BUDGET = 400;                 // All files of all tests.
    localparam int READ_COUNT = 8;
    localparam int WATCHDOG_CYCLES = FILE_BYTE_BUDGET * BYTE_BITS
        + READ_COUNT * (RESULT_BITS + 3) + 8 * (RESET_CYCLES + SETTLE_CYCLES + 1) + 1000;

    logic tck = 1'b0;
    logic tdi;
    logic tdo;
    logic test_logic_reset;
    logic run_test_idle;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;

    logic check_read;                                      // One-cycle strobe per read.
    logic captured;
    result_t read_value;
    result_t expected_value;
    string check_name;
    int error_count;
    int read_count;
    byte_t file_q[$];

    always #(CLK_PERIOD / 2) tck = ~tck;

    user_logic user_logic_i (
        .tck(tck),
        .tdi(tdi),
        .tdo(tdo),
        .test_logic_reset(test_logic_reset),
        .run_test_idle(run_test_idle),
        .ir_is_user(ir_is_user),
        .capture_dr(capture_dr),
        .shift_dr(shift_dr),
        .update_dr(update_dr)
    );

    // **************************************************
    // Checks
    // **************************************************
    read_matches_model: assert property (@(posedge tck) disable iff (test_logic_reset)
        check_read |-> (read_value == expected_value))
    else begin
        error_count++;
        $display("[ERROR] %s: expected %0d, actual %0d", check_name, expected_value, read_value);
    end

    tdo_low_before_capture: assert property (@(posedge tck) disable iff (test_logic_reset)
        !captured |-> !tdo)
    else begin
        error_count++;
        $display("[ERROR] tdo_before_capture: expected 0, actual %0b", tdo);
    end

    // Reference model of the dial.
    function automatic result_t model_count();
        int position;
        int value;
        int landings;
        bit in_line;
        bit left;
        byte_t c;
        position = int'(DIAL_START);
        landings = 0;
        in_line = 1'b0;
        left = 1'b0;
        value = 0;
        for (int i = 0; i < file_q.size(); i++) begin
            c = file_q[i];
            if (c == ASCII_R || c == ASCII_L) begin
                in_line = 1'b1;
                left = (c == ASCII_L);
                value = 0;
            end else if (in_line && c >= ASCII_ZERO && c <= ASCII_NINE) begin
                value = (value * 10 + int'(c - ASCII_ZERO)) % DIAL_SIZE;
            end else if (in_line && (c == ASCII_NEWLINE || c == ASCII_EOT)) begin
                position = left ? (position + DIAL_SIZE - value) % DIAL_SIZE
                                : (position + value) % DIAL_SIZE;
                landings += (position == 0) ? 1 : 0;
                in_line = 1'b0;
            end
            if (c == ASCII_EOT) begin
                break;
            end
        end
        return result_t'(landings);
    endfunction

    `include "tb_jtag_tasks.svh"

    // **************************************************
    // Test sequence
    // **************************************************
    initial begin : run_tests
        result_t first_count;
        int position;
        int count;
        bit left;
        string text;
        tdi = 1'b0;
        test_logic_reset = 1'b1;
        run_test_idle = 1'b0;
        ir_is_user = 1'b0;
        capture_dr = 1'b0;
        shift_dr = 1'b0;
        update_dr = 1'b0;
        check_read = 1'b0;
        captured = 1'b0;
        error_count = 0;
        read_count = 0;
        void'($urandom(SEED));
        apply_reset();
        file_q.delete();
        add_text("R12\n");                                 // Shifted before any capture.
        send_file();
        check_result("reset_read", '0);
        run_file("fixed_file", "R50\nL7\nR157\nL250\nR1\nL1\nR99\nL42\nR42\nL100\n");
        text = "";
        position = int'(DIAL_START);
        for (int n = 0; n < RANDOM_LINES; n++) begin
            left = 1'($urandom % 2);
            count = int'($urandom % 1000);
            if (n % 4 == 3) begin
                left = 1'b0;
                count = (DIAL_SIZE - position) % DIAL_SIZE + DIAL_SIZE * (n % 3);
            end
            position = left ? (position + DIAL_SIZE - count % DIAL_SIZE) % DIAL_SIZE
                            : (position + count) % DIAL_SIZE;
            text = {text, $sformatf("%s%0d", left ? "L" : "R", count)};
            text = ($urandom % 3 == 0) ? {text, "\r\n"} : {text, "\n"};
        end
        run_file("random_file", text);
        run_file("no_final_newline", "R20\nL70");
        apply_reset();
        shift_bits(ASCII_EOT, 5);
        pulse_update();                                    // Drops the five bits.
        file_q.delete();
        add_text("L50\nR100\nR3\nL3\n");
        file_q.push_back(ASCII_EOT);
        first_count = model_count();
        send_file();
        check_result("partial_byte", first_count);
        file_q.delete();
        add_text("R50\nL50\n");
        file_q.push_back(ASCII_EOT);                       // Would land on zero if parsed.
        send_file();
        check_result("after_eot", first_count);
        run_file("first_file", "R50\nR100\n");
        run_file("second_file", "L25\nL25\nR7\n");
        $display("Summary: %0d reads checked, %0d errors", read_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
